// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = l2_cache_tb
FILELIST  = files.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then exit 1; fi
	@grep -q "TESTS PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: files.f
+incdir+source
source/l2_pkg.sv
source/l2_req_arbiter.sv
source/l2_way.sv
source/l2_ctrl.sv
source/l2_cache.sv
verification/l2_tb_clock.sv
verification/l2_cache_sva.sv
verification/l2_cache_tb.sv

// File: source/l2_cache.sv
`timescale 1ns/10ps
`default_nettype none

`include "l2_consts.svh"

module l2_cache (
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    input  wire logic                      icache_req,
    input  wire logic [`L2_ADDR_WIDTH-1:0] icache_addr,
    output logic                           icache_addr_ok,
    output logic                           icache_data_ok,
    output l2_pkg::line_t                  icache_dout,
    input  wire logic                      dcache_req,
    input  wire logic                      dcache_wr,
    input  wire logic [`L2_ADDR_WIDTH-1:0] dcache_addr,
    input  wire logic [31:0]               dcache_din,
    input  wire logic [3:0]                dcache_wstrb,
    output logic                           dcache_addr_ok,
    output logic                           dcache_data_ok,
    output l2_pkg::line_t                  dcache_dout,
    output logic                           mem_req_r,
    output logic [`L2_ADDR_WIDTH-1:0]      mem_addr_r,
    output logic                           mem_req_w,
    output logic [`L2_ADDR_WIDTH-1:0]      mem_addr_w,
    output l2_pkg::line_t                  mem_dout,
    input  wire logic                      mem_addr_ok_r,
    input  wire logic                      mem_addr_ok_w,
    input  wire logic                      mem_data_ok,
    input  wire l2_pkg::line_t             mem_din
);
    import l2_pkg::*;

    localparam int LINE_LSB = `L2_OFFSET_WIDTH + 2;

    logic                      ready;
    logic                      req_valid;
    req_src_e                  req_src;
    logic [`L2_ADDR_WIDTH-1:0] req_addr;
    logic [31:0]               req_wdata;
    logic [3:0]                req_wstrb;
    way_mask_t                 way_hit;
    way_mask_t                 way_valid;
    way_mask_t                 way_dirty;
    way_mask_t                 fill_en;
    way_mask_t                 word_we;
    tag_t [`L2_WAYS-1:0]       victim_tags;
    line_t [`L2_WAYS-1:0]      way_lines;
    line_t                     fill_line;
    line_t                     l2_dout;

    l2_req_arbiter u_arbiter (
        .clk(clk), .rst_n(rst_n),
        .icache_req(icache_req), .icache_addr(icache_addr),
        .dcache_req(dcache_req), .dcache_wr(dcache_wr), .dcache_addr(dcache_addr),
        .dcache_din(dcache_din), .dcache_wstrb(dcache_wstrb), .ready(ready),
        .icache_addr_ok(icache_addr_ok), .dcache_addr_ok(dcache_addr_ok),
        .req_valid(req_valid), .req_src(req_src), .req_addr(req_addr),
        .req_wdata(req_wdata), .req_wstrb(req_wstrb)
    );

    // Every way sees the same held request
    for (genvar w = 0; w < `L2_WAYS; w++) begin : g_way
        l2_way u_way (
            .clk(clk), .rst_n(rst_n),
            .lookup_index(req_addr[LINE_LSB +: `L2_INDEX_WIDTH]),
            .lookup_tag(req_addr[`L2_ADDR_WIDTH-1:LINE_LSB+`L2_INDEX_WIDTH]),
            .fill_en(fill_en[w]), .fill_line(fill_line), .word_we(word_we[w]),
            .word_off(req_addr[2 +: `L2_OFFSET_WIDTH]),
            .word_data(req_wdata), .word_wstrb(req_wstrb),
            .hit(way_hit[w]), .valid(way_valid[w]), .dirty(way_dirty[w]),
            .victim_tag(victim_tags[w]), .line_out(way_lines[w])
        );
    end

    l2_ctrl u_ctrl (
        .clk(clk), .rst_n(rst_n),
        .req_valid(req_valid), .req_src(req_src), .req_addr(req_addr),
        .way_hit(way_hit), .way_valid(way_valid), .way_dirty(way_dirty),
        .victim_tags(victim_tags), .way_lines(way_lines),
        .mem_addr_ok_r(mem_addr_ok_r), .mem_addr_ok_w(mem_addr_ok_w),
        .mem_data_ok(mem_data_ok), .mem_din(mem_din),
        .ready(ready), .fill_en(fill_en), .word_we(word_we), .fill_line(fill_line),
        .icache_data_ok(icache_data_ok), .dcache_data_ok(dcache_data_ok), .dout(l2_dout),
        .mem_req_r(mem_req_r), .mem_addr_r(mem_addr_r),
        .mem_req_w(mem_req_w), .mem_addr_w(mem_addr_w), .mem_dout(mem_dout)
    );

    assign icache_dout = l2_dout;
    assign dcache_dout = l2_dout;

endmodule

`default_nettype wire

// File: source/l2_consts.svh
`ifndef L2_CONSTS_SVH
`define L2_CONSTS_SVH

// Set index bits, four sets
`define L2_INDEX_WIDTH 2

// Word offset bits within a line, four words
`define L2_OFFSET_WIDTH 2

// Ways 0 and 1 take I fills, ways 2 and 3 take D fills
`define L2_WAYS 4

// Byte address width on both L1 and memory sides
`define L2_ADDR_WIDTH 32

`endif

// File: source/l2_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

`include "l2_consts.svh"

module l2_ctrl (
    input  wire logic                          clk,
    input  wire logic                          rst_n,
    input  wire logic                          req_valid,
    input  wire l2_pkg::req_src_e              req_src,
    input  wire logic [`L2_ADDR_WIDTH-1:0]     req_addr,
    input  wire l2_pkg::way_mask_t             way_hit,
    input  wire l2_pkg::way_mask_t             way_valid,
    input  wire l2_pkg::way_mask_t             way_dirty,
    input  wire l2_pkg::tag_t [`L2_WAYS-1:0]   victim_tags,
    input  wire l2_pkg::line_t [`L2_WAYS-1:0]  way_lines,
    input  wire logic                          mem_addr_ok_r,
    input  wire logic                          mem_addr_ok_w,
    input  wire logic                          mem_data_ok,
    input  wire l2_pkg::line_t                 mem_din,
    output logic                               ready,
    output l2_pkg::way_mask_t                  fill_en,
    output l2_pkg::way_mask_t                  word_we,
    output l2_pkg::line_t                      fill_line,
    output logic                               icache_data_ok,
    output logic                               dcache_data_ok,
    output l2_pkg::line_t                      dout,
    output logic                               mem_req_r,
    output logic [`L2_ADDR_WIDTH-1:0]          mem_addr_r,
    output logic                               mem_req_w,
    output logic [`L2_ADDR_WIDTH-1:0]          mem_addr_w,
    output l2_pkg::line_t                      mem_dout
);
    import l2_pkg::*;

    localparam int LINE_LSB = `L2_OFFSET_WIDTH + 2;
    localparam int SETS     = 1 << `L2_INDEX_WIDTH;
    localparam int PAIRS    = `L2_WAYS / 2;
    localparam int WAY_BITS = $clog2(`L2_WAYS);

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOOKUP,
        S_WB,
        S_REFILL,
        S_MERGE,
        S_RESPOND
    } state_e;

    state_e                       state_q;
    state_e                       cur;
    logic                         mem_sent_q;
    logic [SETS-1:0][PAIRS-1:0]   plru_q;
    logic [WAY_BITS-1:0]          victim_q;
    logic [WAY_BITS-1:0]          hit_way;
    logic [WAY_BITS-1:0]          pick_way;
    logic [WAY_BITS-1:0]          sel_way;
    index_t                       index;
    logic                         pair;
    logic                         any_hit;
    logic                         resp;

    assign index   = req_addr[LINE_LSB +: `L2_INDEX_WIDTH];
    assign any_hit = |way_hit;

    // The cycle that carries req_valid is the lookup
    assign cur   = (state_q == S_IDLE && req_valid) ? S_LOOKUP : state_q;
    assign ready = (cur == S_IDLE);

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < `L2_WAYS; w++) begin
            if (way_hit[w]) begin
                hit_way = WAY_BITS'(w);
            end
        end
    end

    // First invalid way of the pair, else the one not used last
    assign pair = (req_src != src_icache);

    always_comb begin
        if (!way_valid[{pair, 1'b0}]) begin
            pick_way = {pair, 1'b0};
        end else if (!way_valid[{pair, 1'b1}]) begin
            pick_way = {pair, 1'b1};
        end else begin
            pick_way = {pair, ~plru_q[index][pair]};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q    <= S_IDLE;
            mem_sent_q <= 1'b0;
            plru_q     <= '0;
        end else begin
            case (cur)
                S_LOOKUP: begin
                    if (any_hit) begin
                        plru_q[index][hit_way[1]] <= hit_way[0];
                        state_q <= S_IDLE;
                    end else if (way_valid[pick_way] && way_dirty[pick_way]) begin
                        state_q <= S_WB;
                    end else begin
                        state_q <= S_REFILL;
                    end
                end
                S_WB: begin
                    if (mem_sent_q && mem_data_ok) begin
                        mem_sent_q <= 1'b0;
                        state_q    <= S_REFILL;
                    end else if (mem_addr_ok_w) begin
                        mem_sent_q <= 1'b1;
                    end
                end
                S_REFILL: begin
                    if (mem_sent_q && mem_data_ok) begin
                        mem_sent_q <= 1'b0;
                        plru_q[index][victim_q[1]] <= victim_q[0];
                        state_q <= (req_src == src_dwrite) ? S_MERGE : S_RESPOND;
                    end else if (mem_addr_ok_r) begin
                        mem_sent_q <= 1'b1;
                    end
                end
                S_MERGE:   state_q <= S_RESPOND;
                S_RESPOND: state_q <= S_IDLE;
                default:   state_q <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (cur == S_LOOKUP) begin
            victim_q <= pick_way;
        end
    end

    // Way writes
    assign fill_line = mem_din;
    assign fill_en   = (cur == S_REFILL && mem_sent_q && mem_data_ok) ?
                       way_mask_t'(1) << victim_q : '0;

    always_comb begin
        if (cur == S_LOOKUP && any_hit && req_src == src_dwrite) begin
            word_we = way_hit;
        end else if (cur == S_MERGE) begin
            word_we = way_mask_t'(1) << victim_q;
        end else begin
            word_we = '0;
        end
    end

    // L1 response
    assign sel_way        = (cur == S_LOOKUP) ? hit_way : victim_q;
    assign dout           = way_lines[sel_way];
    assign resp           = (cur == S_LOOKUP && any_hit) || (cur == S_RESPOND);
    assign icache_data_ok = resp && (req_src == src_icache);
    assign dcache_data_ok = resp && (req_src == src_dread || req_src == src_dwrite);

    // Memory side, one transaction open at a time
    assign mem_req_w  = (cur == S_WB) && !mem_sent_q;
    assign mem_addr_w = {victim_tags[victim_q], index, {LINE_LSB{1'b0}}};
    assign mem_dout   = way_lines[victim_q];
    assign mem_req_r  = (cur == S_REFILL) && !mem_sent_q;
    assign mem_addr_r = {req_addr[`L2_ADDR_WIDTH-1:LINE_LSB], {LINE_LSB{1'b0}}};

endmodule

`default_nettype wire

// File: source/l2_pkg.sv
`default_nettype none

`include "l2_consts.svh"

package l2_pkg;

    // Source of the accepted request
    typedef enum logic [1:0] {
        src_none,
        src_icache,
        src_dread,
        src_dwrite
    } req_src_e;

    typedef logic [`L2_ADDR_WIDTH-`L2_INDEX_WIDTH-`L2_OFFSET_WIDTH-3:0] tag_t;
    typedef logic [`L2_INDEX_WIDTH-1:0] index_t;
    typedef logic [`L2_OFFSET_WIDTH-1:0] word_off_t;

    // Word 0 sits in the low bits
    typedef logic [32*(1<<`L2_OFFSET_WIDTH)-1:0] line_t;

    typedef logic [`L2_WAYS-1:0] way_mask_t;

endpackage

`default_nettype wire

// File: source/l2_req_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

`include "l2_consts.svh"

module l2_req_arbiter (
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    input  wire logic                      icache_req,
    input  wire logic [`L2_ADDR_WIDTH-1:0] icache_addr,
    input  wire logic                      dcache_req,
    input  wire logic                      dcache_wr,
    input  wire logic [`L2_ADDR_WIDTH-1:0] dcache_addr,
    input  wire logic [31:0]               dcache_din,
    input  wire logic [3:0]                dcache_wstrb,
    input  wire logic                      ready,
    output logic                           icache_addr_ok,
    output logic                           dcache_addr_ok,
    output logic                           req_valid,
    output l2_pkg::req_src_e               req_src,
    output logic [`L2_ADDR_WIDTH-1:0]      req_addr,
    output logic [31:0]                    req_wdata,
    output logic [3:0]                     req_wstrb
);
    import l2_pkg::*;

    logic accept;

    // D side wins, I waits until no D request is pending
    assign dcache_addr_ok = ready & dcache_req;
    assign icache_addr_ok = ready & icache_req & ~dcache_req;
    assign accept         = dcache_addr_ok | icache_addr_ok;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            req_valid <= 1'b0;
            req_src   <= src_none;
        end else begin
            req_valid <= accept;
            if (accept) begin
                if (dcache_req) begin
                    req_src <= dcache_wr ? src_dwrite : src_dread;
                end else begin
                    req_src <= src_icache;
                end
            end
        end
    end

    // Request buffer, held until the next acceptance
    always_ff @(posedge clk) begin
        if (accept) begin
            req_addr  <= dcache_req ? dcache_addr : icache_addr;
            req_wdata <= dcache_din;
            req_wstrb <= dcache_wstrb;
        end
    end

endmodule

`default_nettype wire

// File: source/l2_way.sv
`timescale 1ns/10ps
`default_nettype none

`include "l2_consts.svh"

module l2_way (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire l2_pkg::index_t    lookup_index,
    input  wire l2_pkg::tag_t      lookup_tag,
    input  wire logic              fill_en,
    input  wire l2_pkg::line_t     fill_line,
    input  wire logic              word_we,
    input  wire l2_pkg::word_off_t word_off,
    input  wire logic [31:0]       word_data,
    input  wire logic [3:0]        word_wstrb,
    output logic                   hit,
    output logic                   valid,
    output logic                   dirty,
    output l2_pkg::tag_t           victim_tag,
    output l2_pkg::line_t          line_out
);
    import l2_pkg::*;

    localparam int SETS = 1 << `L2_INDEX_WIDTH;

    logic [SETS-1:0] valid_q;
    logic [SETS-1:0] dirty_q;
    tag_t            tag_q  [SETS];
    line_t           line_q [SETS];

    assign valid      = valid_q[lookup_index];
    assign dirty      = dirty_q[lookup_index];
    assign victim_tag = tag_q[lookup_index];
    assign line_out   = line_q[lookup_index];
    assign hit        = valid_q[lookup_index] && (tag_q[lookup_index] == lookup_tag);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (fill_en) begin
            valid_q[lookup_index] <= 1'b1;
            dirty_q[lookup_index] <= 1'b0;
        end else if (word_we) begin
            dirty_q[lookup_index] <= 1'b1;
        end
    end

    // Whole line on fill, otherwise byte merge into one word
    always_ff @(posedge clk) begin
        if (fill_en) begin
            tag_q[lookup_index]  <= lookup_tag;
            line_q[lookup_index] <= fill_line;
        end else if (word_we) begin
            for (int b = 0; b < 4; b++) begin
                if (word_wstrb[b]) begin
                    line_q[lookup_index][32*word_off + 8*b +: 8] <= word_data[8*b +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: verification/l2_cache_sva.sv
`timescale 1ns/10ps
`default_nettype none

module l2_cache_sva (
    input wire logic clk,
    input wire logic rst_n,
    input wire logic icache_req,
    input wire logic icache_addr_ok,
    input wire logic dcache_req,
    input wire logic dcache_addr_ok,
    input wire logic icache_data_ok,
    input wire logic dcache_data_ok,
    input wire logic mem_req_r,
    input wire logic mem_req_w,
    input wire logic mem_addr_ok_r
);

    a_i_addr_ok_req: assert property (@(posedge clk) disable iff (!rst_n)
        icache_addr_ok |-> icache_req)
        else $error("icache_addr_ok without icache_req");

    a_d_addr_ok_req: assert property (@(posedge clk) disable iff (!rst_n)
        dcache_addr_ok |-> dcache_req)
        else $error("dcache_addr_ok without dcache_req");

    a_one_data_ok: assert property (@(posedge clk) disable iff (!rst_n)
        !(icache_data_ok && dcache_data_ok))
        else $error("both data_ok strobes high");

    a_one_mem_req: assert property (@(posedge clk) disable iff (!rst_n)
        !(mem_req_r && mem_req_w))
        else $error("memory read and write requested together");

    // Read request must stay up until the memory takes it
    a_mem_req_r_held: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_req_r && !mem_addr_ok_r) |=> mem_req_r)
        else $error("mem_req_r dropped before mem_addr_ok_r");

endmodule

bind l2_cache l2_cache_sva u_sva (
    .clk(clk), .rst_n(rst_n),
    .icache_req(icache_req), .icache_addr_ok(icache_addr_ok),
    .dcache_req(dcache_req), .dcache_addr_ok(dcache_addr_ok),
    .icache_data_ok(icache_data_ok), .dcache_data_ok(dcache_data_ok),
    .mem_req_r(mem_req_r), .mem_req_w(mem_req_w), .mem_addr_ok_r(mem_addr_ok_r)
);

`default_nettype wire

// File: verification/l2_cache_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "l2_consts.svh"

module l2_cache_tb;
    import l2_pkg::*;

    localparam int LIMIT     = 200;
    localparam int MEM_LINES = 256;

    logic        clk;
    logic        rst_n = 1'b0;
    logic        icache_req;
    logic [31:0] icache_addr;
    logic        icache_addr_ok;
    logic        icache_data_ok;
    line_t       icache_dout;
    logic        dcache_req;
    logic        dcache_wr;
    logic [31:0] dcache_addr;
    logic [31:0] dcache_din;
    logic [3:0]  dcache_wstrb;
    logic        dcache_addr_ok;
    logic        dcache_data_ok;
    line_t       dcache_dout;
    logic        mem_req_r;
    logic [31:0] mem_addr_r;
    logic        mem_req_w;
    logic [31:0] mem_addr_w;
    line_t       mem_dout;
    logic        mem_addr_ok_r = 1'b0;
    logic        mem_addr_ok_w = 1'b0;
    logic        mem_data_ok = 1'b0;
    line_t       mem_din = '0;

    // Memory model state
    line_t       mem_lines [MEM_LINES];
    logic [1:0]  mem_phase;
    logic [2:0]  mem_delay;
    logic        mem_is_write;
    logic [7:0]  mem_line_idx;
    line_t       mem_wline;
    integer      seed = 22;
    int          read_count;

    int          tests = 0;
    int          checks = 0;
    int          errors = 0;
    logic        timed_out = 1'b0;

    l2_tb_clock u_clock (.clk(clk));

    l2_cache UUT (
        .clk(clk), .rst_n(rst_n),
        .icache_req(icache_req), .icache_addr(icache_addr),
        .icache_addr_ok(icache_addr_ok), .icache_data_ok(icache_data_ok),
        .icache_dout(icache_dout),
        .dcache_req(dcache_req), .dcache_wr(dcache_wr), .dcache_addr(dcache_addr),
        .dcache_din(dcache_din), .dcache_wstrb(dcache_wstrb),
        .dcache_addr_ok(dcache_addr_ok), .dcache_data_ok(dcache_data_ok),
        .dcache_dout(dcache_dout),
        .mem_req_r(mem_req_r), .mem_addr_r(mem_addr_r),
        .mem_req_w(mem_req_w), .mem_addr_w(mem_addr_w), .mem_dout(mem_dout),
        .mem_addr_ok_r(mem_addr_ok_r), .mem_addr_ok_w(mem_addr_ok_w),
        .mem_data_ok(mem_data_ok), .mem_din(mem_din)
    );

    // Memory: address phase then data phase, each 1 to 4 cycles late
    always @(posedge clk) begin
        if (!rst_n) begin
            mem_phase     <= 2'd0;
            mem_delay     <= 3'd0;
            mem_addr_ok_r <= 1'b0;
            mem_addr_ok_w <= 1'b0;
            mem_data_ok   <= 1'b0;
            read_count    <= 0;
            for (int l = 0; l < MEM_LINES; l++) begin
                for (int w = 0; w < 4; w++) begin
                    mem_lines[l][32*w +: 32] <= {20'd0, l[7:0], w[1:0], 2'b00} ^ 32'hA5A5_0000;
                end
            end
        end else begin
            case (mem_phase)
                2'd0: begin
                    if (mem_req_r || mem_req_w) begin
                        mem_is_write <= mem_req_w;
                        mem_delay    <= 3'(32'd1 + {$random(seed)} % 32'd4);
                        mem_phase    <= 2'd1;
                    end
                end
                2'd1: begin
                    if (mem_delay > 3'd1) begin
                        mem_delay <= mem_delay - 3'd1;
                    end else begin
                        if (mem_is_write) begin
                            mem_addr_ok_w <= 1'b1;
                            mem_line_idx  <= mem_addr_w[11:4];
                            mem_wline     <= mem_dout;
                        end else begin
                            mem_addr_ok_r <= 1'b1;
                            mem_line_idx  <= mem_addr_r[11:4];
                        end
                        mem_delay <= 3'(32'd1 + {$random(seed)} % 32'd4);
                        mem_phase <= 2'd2;
                    end
                end
                2'd2: begin
                    mem_addr_ok_r <= 1'b0;
                    mem_addr_ok_w <= 1'b0;
                    if (mem_delay > 3'd1) begin
                        mem_delay <= mem_delay - 3'd1;
                    end else begin
                        mem_data_ok <= 1'b1;
                        if (mem_is_write) begin
                            mem_lines[mem_line_idx] <= mem_wline;
                        end else begin
                            mem_din    <= mem_lines[mem_line_idx];
                            read_count <= read_count + 1;
                        end
                        mem_phase <= 2'd3;
                    end
                end
                default: begin
                    mem_data_ok <= 1'b0;
                    mem_phase   <= 2'd0;
                end
            endcase
        end
    end

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // Op 0 I read, 1 D read, 2 D write, 3 I and D read together
    task automatic run_test(input int op, input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] strb, input logic [31:0] exp_word,
                            input int exp_reads);
        line_t d_line;
        line_t i_line;
        int    errors_before;
        int    n;
        int    d_cycle;
        int    i_cycle;
        int    off;
        logic  d_pend;
        logic  i_pend;
        logic  d_wait;
        logic  i_wait;
        logic  d_ok_now;
        logic  i_ok_now;
        errors_before = errors;
        tests++;
        d_pend  = (op != 0);
        i_pend  = (op == 0 || op == 3);
        d_wait  = d_pend;
        i_wait  = i_pend;
        d_cycle = -1;
        i_cycle = -1;
        d_line  = '0;
        i_line  = '0;
        n       = 0;
        off     = int'(addr[3:2]);
        @(posedge clk);
        if (d_pend) begin
            dcache_req   <= 1'b1;
            dcache_wr    <= (op == 2);
            dcache_addr  <= addr;
            dcache_din   <= wdata;
            dcache_wstrb <= strb;
        end
        if (i_pend) begin
            icache_req  <= 1'b1;
            icache_addr <= addr;
        end
        while ((d_pend || i_pend || d_wait || i_wait) && n < LIMIT) begin
            @(negedge clk);
            d_ok_now = dcache_req && dcache_addr_ok;
            i_ok_now = icache_req && icache_addr_ok;
            if (d_ok_now) begin
                d_pend  = 1'b0;
                d_cycle = n;
            end
            if (i_ok_now) begin
                i_pend  = 1'b0;
                i_cycle = n;
            end
            if (dcache_data_ok) begin
                d_wait = 1'b0;
                d_line = dcache_dout;
            end
            if (icache_data_ok) begin
                i_wait = 1'b0;
                i_line = icache_dout;
            end
            n++;
            @(posedge clk);
            if (d_ok_now) dcache_req <= 1'b0;
            if (i_ok_now) icache_req <= 1'b0;
        end
        if (n >= LIMIT) begin
            $display("Timeout: test %0d stalled waiting for a handshake from the cache", tests);
            timed_out = 1'b1;
            errors++;
        end else begin
            if (op == 3) begin
                check_value({31'd0, d_cycle < i_cycle}, 32'd1, "D accepted before I");
            end
            if (op == 1 || op == 3) begin
                check_value(d_line[32*off +: 32], exp_word, "D read word");
            end
            if (op == 0 || op == 3) begin
                check_value(i_line[32*off +: 32], exp_word, "I read word");
            end
            check_value(32'(read_count), 32'(exp_reads), "memory read count");
        end
        $display("Test %0d op %0d addr %h: %s", tests, op, addr,
                 (errors == errors_before) ? "ok" : "failed");
    endtask

    initial begin
        int          fd;
        int          op;
        int          exp_reads;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  strb;
        logic [31:0] exp_word;
        string       text;
        icache_req   = 1'b0;
        icache_addr  = '0;
        dcache_req   = 1'b0;
        dcache_wr    = 1'b0;
        dcache_addr  = '0;
        dcache_din   = '0;
        dcache_wstrb = '0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        fd = $fopen("verification/l2_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file");
            errors++;
        end else begin
            while (!$feof(fd) && !timed_out) begin
                if ($fgets(text, fd) != 0 && text.len() > 0 && text[0] != "#") begin
                    if ($sscanf(text, "%d %h %h %h %h %d", op, addr, wdata, strb,
                                exp_word, exp_reads) == 6) begin
                        run_test(op, addr, wdata, strb, exp_word, exp_reads);
                    end
                end
            end
            $fclose(fd);
        end
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/l2_stimulus.txt
# op (0 I read, 1 D read, 2 D write, 3 I and D read) addr wdata strb exp_word exp_reads
# exp_word is the word at the addressed offset, ignored for writes
0 00000104 00000000 0 a5a50104 1
0 00000104 00000000 0 a5a50104 1
2 00000214 11223344 3 00000000 2
1 00000214 00000000 0 a5a53344 2
2 00000218 deadbeef c 00000000 2
1 00000218 00000000 0 dead0218 2
3 00000328 00000000 0 a5a50328 3
2 00000034 cafef00d f 00000000 4
1 00000070 00000000 0 a5a50070 5
1 000000b0 00000000 0 a5a500b0 6
1 00000034 00000000 0 cafef00d 7
0 00000010 00000000 0 a5a50010 8
0 00000050 00000000 0 a5a50050 9
0 00000090 00000000 0 a5a50090 10
1 00000214 00000000 0 a5a53344 10
0 00000104 00000000 0 a5a50104 10

// File: verification/l2_tb_clock.sv
`timescale 1ns/10ps
`default_nettype none

module l2_tb_clock #(
    parameter real PERIOD = 8.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2.0) clk = ~clk;
    end

endmodule

`default_nettype wire
